// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vector_alu_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "Simulation ended without a pass"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/aes_round_unit.sv ====
`timescale 1ns/10ps

module aes_round_unit (
	vec_op_if.aes ops
);

	// Multiply by x in GF(2^8), reduction poly 0x11b
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// One state column through the MixColumns matrix
	function automatic logic [31:0] mix_column(input logic [31:0] col);
		logic [7:0] s0;
		logic [7:0] s1;
		logic [7:0] s2;
		logic [7:0] s3;
		logic [31:0] m;
		s0 = col[7:0];   // Row 0
		s1 = col[15:8];
		s2 = col[23:16];
		s3 = col[31:24]; // Row 3
		m[7:0]   = xtime(s0) ^ xtime(s1) ^ s1 ^ s2 ^ s3;
		m[15:8]  = s0 ^ xtime(s1) ^ xtime(s2) ^ s2 ^ s3;
		m[23:16] = s0 ^ s1 ^ xtime(s2) ^ xtime(s3) ^ s3;
		m[31:24] = xtime(s0) ^ s0 ^ s1 ^ s2 ^ xtime(s3);
		return m;
	endfunction

	logic [vec_pkg::VEC_W-1:0] key_added;
	logic [vec_pkg::VEC_W-1:0] shifted;
	logic [vec_pkg::VEC_W-1:0] mixed;
	logic [vec_pkg::VEC_W-1:0] rotated;
	logic [vec_pkg::VEC_W-1:0] rcon_added;
	logic [3:0] rcon_idx;
	logic [7:0] rcon_byte;

	assign key_added = ops.src_a ^ ops.src_b;

	// Byte i is row i%4, column i/4
	// Row r moves left by r columns, so output column c reads column (c+r)%4
	for (genvar i = 0; i < vec_pkg::LANES; i++) begin : g_shift
		assign shifted[vec_pkg::LANE_W*i +: vec_pkg::LANE_W] =
			ops.src_a[vec_pkg::LANE_W*((((i / 4) + (i % 4)) % 4) * 4 + (i % 4))
				+: vec_pkg::LANE_W];
	end

	// Rounds 1..10 only, anything else adds nothing
	assign rcon_idx = ops.src_b[3:0];
	assign rcon_byte = (rcon_idx >= 4'd1 && rcon_idx <= 4'd10) ?
		vec_pkg::RCON_TABLE[rcon_idx] : 8'h00;

	for (genvar w = 0; w < vec_pkg::WORDS; w++) begin : g_word
		logic [vec_pkg::WORD_W-1:0] word;

		assign word = ops.src_a[vec_pkg::WORD_W*w +: vec_pkg::WORD_W];

		assign mixed[vec_pkg::WORD_W*w +: vec_pkg::WORD_W] = mix_column(word);
		// Byte 0 lands on top, the rest move down one byte
		assign rotated[vec_pkg::WORD_W*w +: vec_pkg::WORD_W] = {word[7:0], word[31:8]};
		assign rcon_added[vec_pkg::WORD_W*w +: vec_pkg::WORD_W] = word ^ {24'h0, rcon_byte};
	end

	always_comb begin
		case (ops.op)
			vec_pkg::OP_ADD_ROUND_KEY: ops.aes_result = key_added;
			vec_pkg::OP_SHIFT_ROWS:    ops.aes_result = shifted;
			vec_pkg::OP_MIX_COLUMNS:   ops.aes_result = mixed;
			vec_pkg::OP_ROT_WORD:      ops.aes_result = rotated;
			vec_pkg::OP_RCON:          ops.aes_result = rcon_added;
			default:                   ops.aes_result = '0; // Lane ops and unused codes
		endcase
	end

endmodule

// ==== rtl/lane_alu_array.sv ====
`timescale 1ns/10ps

module lane_alu_array (
	vec_op_if.lane ops
);

	// Sixteen byte lanes, all decoding the same opcode
	for (genvar i = 0; i < vec_pkg::LANES; i++) begin : g_lane
		logic [vec_pkg::LANE_W-1:0] a;
		logic [vec_pkg::LANE_W-1:0] b;
		logic [vec_pkg::LANE_W-1:0] y;
		logic [2:0] shamt;

		assign a = ops.src_a[vec_pkg::LANE_W*i +: vec_pkg::LANE_W];
		assign b = ops.src_b[vec_pkg::LANE_W*i +: vec_pkg::LANE_W];
		assign shamt = b[2:0]; // Upper bits of b ignored for shifts

		always_comb begin
			case (ops.op)
				vec_pkg::OP_ADD: y = a + b; // Wraps, no carry to next lane
				vec_pkg::OP_SUB: y = a - b;
				vec_pkg::OP_AND: y = a & b;
				vec_pkg::OP_OR:  y = a | b;
				vec_pkg::OP_XOR: y = a ^ b;
				vec_pkg::OP_SHL: y = a << shamt;
				vec_pkg::OP_SHR: y = a >> shamt; // Logical
				vec_pkg::OP_MIN: y = (a < b) ? a : b;
				// AES opcodes and unused codes
				default: y = '0;
			endcase
		end

		assign ops.lane_result[vec_pkg::LANE_W*i +: vec_pkg::LANE_W] = y;
	end

endmodule

// ==== rtl/vec_op_if.sv ====
`timescale 1ns/10ps

interface vec_op_if;

	vec_pkg::vec_op_e op;
	logic [vec_pkg::VEC_W-1:0] src_a;
	logic [vec_pkg::VEC_W-1:0] src_b;

	// Partial results, one per execution block
	logic [vec_pkg::VEC_W-1:0] lane_result;
	logic [vec_pkg::VEC_W-1:0] aes_result;

	modport issue (
		output op,
		output src_a,
		output src_b,
		input  lane_result,
		input  aes_result
	);

	modport lane (
		input  op,
		input  src_a,
		input  src_b,
		output lane_result
	);

	modport aes (
		input  op,
		input  src_a,
		input  src_b,
		output aes_result
	);

endinterface

// ==== rtl/vec_pkg.sv ====
package vec_pkg;

	localparam int VEC_W = 128;
	localparam int LANE_W = 8;
	localparam int LANES = VEC_W / LANE_W;

	// One AES column is one 32-bit word
	localparam int WORD_W = 32;
	localparam int WORDS = VEC_W / WORD_W;

	// Lane ops sit at 0..7 and AES ops at 19..23
	typedef enum logic [4:0] {
		OP_ADD           = 5'd0,
		OP_SUB           = 5'd1,
		OP_AND           = 5'd2,
		OP_OR            = 5'd3,
		OP_XOR           = 5'd4,
		OP_SHL           = 5'd5,  // Shift by low 3 bits of b
		OP_SHR           = 5'd6,
		OP_MIN           = 5'd7,  // Unsigned
		OP_ADD_ROUND_KEY = 5'd19,
		OP_SHIFT_ROWS    = 5'd20,
		OP_MIX_COLUMNS   = 5'd21,
		OP_ROT_WORD      = 5'd22,
		OP_RCON          = 5'd23
	} vec_op_e;

	// AES round constants
	// Entry 0 has no round, kept as zero so the table indexes by round number
	localparam logic [7:0] RCON_TABLE [0:10] = '{
		8'h00,
		8'h01,
		8'h02,
		8'h04,
		8'h08,
		8'h10,
		8'h20,
		8'h40,
		8'h80,
		8'h1b,
		8'h36
	};

endpackage

// ==== rtl/vector_alu.sv ====
`timescale 1ns/10ps

module vector_alu (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  vec_pkg::vec_op_e          in_op,
	input  logic [vec_pkg::VEC_W-1:0] in_src_a,
	input  logic [vec_pkg::VEC_W-1:0] in_src_b,
	output logic                      in_ready,
	output logic                      out_valid,
	output logic [vec_pkg::VEC_W-1:0] out_result,
	input  logic                      out_ready
);

	vec_op_if ops ();

	// Handshake, operand fan-out and the only register
	vector_result_stage u_stage (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_src_a   (in_src_a),
		.in_src_b   (in_src_b),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_ready  (out_ready),
		.ops        (ops.issue)
	);

	lane_alu_array u_lanes (
		.ops (ops.lane)
	);

	aes_round_unit u_aes (
		.ops (ops.aes)
	);

endmodule

// ==== rtl/vector_result_stage.sv ====
`timescale 1ns/10ps

module vector_result_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  vec_pkg::vec_op_e          in_op,
	input  logic [vec_pkg::VEC_W-1:0] in_src_a,
	input  logic [vec_pkg::VEC_W-1:0] in_src_b,
	output logic                      in_ready,
	output logic                      out_valid,
	output logic [vec_pkg::VEC_W-1:0] out_result,
	input  logic                      out_ready,
	vec_op_if.issue                   ops
);

	logic accept;
	logic [vec_pkg::VEC_W-1:0] sel_result;

	// Both blocks see the incoming instruction directly
	assign ops.op = in_op;
	assign ops.src_a = in_src_a;
	assign ops.src_b = in_src_b;

	// Free slot now, or the held result leaves this edge
	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	// Pick by opcode class
	always_comb begin
		case (in_op)
			vec_pkg::OP_ADD,
			vec_pkg::OP_SUB,
			vec_pkg::OP_AND,
			vec_pkg::OP_OR,
			vec_pkg::OP_XOR,
			vec_pkg::OP_SHL,
			vec_pkg::OP_SHR,
			vec_pkg::OP_MIN:
				sel_result = ops.lane_result;
			vec_pkg::OP_ADD_ROUND_KEY,
			vec_pkg::OP_SHIFT_ROWS,
			vec_pkg::OP_MIX_COLUMNS,
			vec_pkg::OP_ROT_WORD,
			vec_pkg::OP_RCON:
				sel_result = ops.aes_result;
			default:
				sel_result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid; // Refill or drain
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_result <= sel_result;
		end
	end

	// Held result must not move under back-pressure
	a_stall_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_result))
		else $error("out_result changed while stalled");

	a_valid_from_accept: assert property (@(posedge clk) disable iff (reset)
		$rose(out_valid) |-> $past(accept))
		else $error("out_valid rose without an accepted input");

endmodule

// ==== sim.f ====
+incdir+include
rtl/vec_pkg.sv
rtl/vec_op_if.sv
rtl/lane_alu_array.sv
rtl/aes_round_unit.sv
rtl/vector_result_stage.sv
rtl/vector_alu.sv
tb/vector_alu_tb.sv

// ==== include/vector_alu_model.svh ====
`ifndef VECTOR_ALU_MODEL_SVH
`define VECTOR_ALU_MODEL_SVH

function automatic logic [7:0] model_lane_byte(vec_pkg::vec_op_e op, logic [7:0] a,
	logic [7:0] b);
	case (op)
		vec_pkg::OP_ADD: return a + b;
		vec_pkg::OP_SUB: return a - b;
		vec_pkg::OP_AND: return a & b;
		vec_pkg::OP_OR:  return a | b;
		vec_pkg::OP_XOR: return a ^ b;
		vec_pkg::OP_SHL: return a << b[2:0];
		vec_pkg::OP_SHR: return a >> b[2:0];
		vec_pkg::OP_MIN: return (b < a) ? b : a;
		default:         return 8'h00;
	endcase
endfunction

function automatic logic [7:0] model_xtime(logic [7:0] b);
	return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
endfunction

function automatic logic [127:0] model_shift_rows(logic [127:0] a);
	logic [127:0] y;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			y[8*(4*c + r) +: 8] = a[8*(4*((c + r) % 4) + r) +: 8];
		end
	end
	return y;
endfunction

// Circulant 02 03 01 01 down each column
function automatic logic [127:0] model_mix_columns(logic [127:0] a);
	logic [127:0] y;
	logic [7:0] s [4];
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			s[r] = a[8*(4*c + r) +: 8];
		end
		for (int r = 0; r < 4; r++) begin
			y[8*(4*c + r) +: 8] = model_xtime(s[r]) ^ model_xtime(s[(r + 1) % 4]) ^
				s[(r + 1) % 4] ^ s[(r + 2) % 4] ^ s[(r + 3) % 4];
		end
	end
	return y;
endfunction

function automatic logic [127:0] model_rot_word(logic [127:0] a);
	logic [127:0] y;
	for (int w = 0; w < 4; w++) begin
		for (int k = 0; k < 4; k++) begin
			y[8*(4*w + k) +: 8] = a[8*(4*w + (k + 1) % 4) +: 8];
		end
	end
	return y;
endfunction

function automatic logic [127:0] model_rcon(logic [127:0] a, logic [127:0] b);
	logic [7:0] rc;
	logic [127:0] y;
	rc = 8'h00;
	if (b[3:0] != 4'd0 && b[3:0] <= 4'd10) begin
		rc = vec_pkg::RCON_TABLE[b[3:0]];
	end
	y = a;
	for (int w = 0; w < 4; w++) begin
		y[32*w +: 8] = a[32*w +: 8] ^ rc;
	end
	return y;
endfunction

// Expected result for any opcode
function automatic logic [127:0] vector_alu_model(vec_pkg::vec_op_e op, logic [127:0] a,
	logic [127:0] b);
	logic [127:0] y;
	y = '0;
	case (op)
		vec_pkg::OP_ADD_ROUND_KEY: y = a ^ b;
		vec_pkg::OP_SHIFT_ROWS:    y = model_shift_rows(a);
		vec_pkg::OP_MIX_COLUMNS:   y = model_mix_columns(a);
		vec_pkg::OP_ROT_WORD:      y = model_rot_word(a);
		vec_pkg::OP_RCON:          y = model_rcon(a, b);
		default: begin
			for (int i = 0; i < 16; i++) begin
				y[8*i +: 8] = model_lane_byte(op, a[8*i +: 8], b[8*i +: 8]);
			end
		end
	endcase
	return y;
endfunction

`endif

// ==== tb/vector_alu_tb.sv ====
`timescale 1ns/10ps

module vector_alu_tb;

	`include "vector_alu_model.svh"

	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic [4:0]   op;
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] exp;
	} vec_case_t;

	logic clk;
	logic reset;
	logic in_valid;
	vec_pkg::vec_op_e in_op;
	logic [127:0] in_src_a;
	logic [127:0] in_src_b;
	logic in_ready;
	logic out_valid;
	logic [127:0] out_result;
	logic out_ready;

	vec_case_t cases [$];
	logic [127:0] exp_q [$];
	int acc_q [$];
	int cycle;
	int acc_cycle;
	logic strict;       // Exact one-cycle latency expected with ready held high
	logic ready_random;
	logic held;
	logic [127:0] held_value;
	logic [127:0] tmp;

	vector_alu u_dut (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_src_a   (in_src_a),
		.in_src_b   (in_src_b),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_ready  (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	always @(posedge clk) begin
		if (ready_random) begin
			out_ready <= 1'($urandom % 2);
		end else begin
			out_ready <= 1'b1;
		end
	end

	task automatic compare(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s mismatch, got %h expected %h",
				$time, what, got, exp);
			$display("test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
		$display("test failed");
		$fatal(1, "stopping on timeout");
	endtask

	// Output order, stall stability and latency
	always @(posedge clk) begin
		if (!reset && out_valid) begin
			if (held) compare("stalled out_result", out_result, held_value);
			if (out_ready) begin
				if (exp_q.size() == 0) begin
					$display("A result came out with no instruction outstanding");
					$display("test failed");
					$fatal(1, "stopping on extra result");
				end
				compare("out_result", out_result, exp_q.pop_front());
				acc_cycle = acc_q.pop_front();
				if (strict) compare("latency in cycles", cycle - acc_cycle, 1);
			end
			held = !out_ready;
			held_value = out_result;
		end else begin
			held = 1'b0;
		end
	end

	task automatic add_case(input logic [4:0] op, input logic [127:0] a,
		input logic [127:0] b);
		vec_case_t c;
		c.op = op;
		c.a = a;
		c.b = b;
		c.exp = vector_alu_model(vec_pkg::vec_op_e'(op), a, b);
		cases.push_back(c);
	endtask

	// Called on a rising edge, returns on the accepting edge
	task automatic apply_case(input vec_case_t c);
		int waited;
		waited = 0;
		in_valid <= 1'b1;
		in_op <= vec_pkg::vec_op_e'(c.op);
		in_src_a <= c.a;
		in_src_b <= c.b;
		do begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("in_ready");
		end while (!in_ready);
		if (strict) compare("cycles to accept", waited, 1);
		exp_q.push_back(c.exp);
		acc_q.push_back(cycle);
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("outstanding results");
		end
	endtask

	initial begin
		void'($urandom(32'he4ee));
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = vec_pkg::OP_ADD;
		in_src_a = '0;
		in_src_b = '0;
		out_ready = 1'b0;
		cycle = 0;
		strict = 1'b0;
		ready_random = 1'b1;
		held = 1'b0;
		held_value = '0;

		// Model checked against published answers
		tmp = vector_alu_model(vec_pkg::OP_MIX_COLUMNS, 128'h455313db, '0);
		compare("FIPS MixColumns column", tmp[31:0], 32'hbca14d8e);
		tmp = vector_alu_model(vec_pkg::OP_SHIFT_ROWS,
			128'h0f0e0d0c_0b0a0908_07060504_03020100, '0);
		compare("ShiftRows reference", tmp, 128'h0b06010c_07020d08_030e0904_0f0a0500);

		add_case(5'd21, 128'hd5d4d4d4_c6c6c6c6_01010101_455313db, '0);
		add_case(5'd20, 128'h0f0e0d0c_0b0a0908_07060504_03020100, '0);
		add_case(5'd22, 128'h0f0e0d0c_0b0a0908_07060504_03020100, '0);
		add_case(5'd19, 128'h00112233_44556677_8899aabb_ccddeeff,
			128'h0f1571c9_47d9e859_0cb7add6_af7f6798);
		add_case(5'd23, 128'h09cf4f3c_09cf4f3c_09cf4f3c_09cf4f3c, 128'h1);
		add_case(5'd23, 128'h09cf4f3c_09cf4f3c_09cf4f3c_09cf4f3c, 128'ha);
		add_case(5'd23, 128'h09cf4f3c_09cf4f3c_09cf4f3c_09cf4f3c, 128'h0);
		add_case(5'd23, 128'h09cf4f3c_09cf4f3c_09cf4f3c_09cf4f3c, 128'hffff_000c); // Out of range
		add_case(5'd0, {16{8'hff}}, 128'h01020304_05060708_090a0b0c_0d0e0f80); // Add wraps
		add_case(5'd1, '0, 128'h01020304_05060708_090a0b0c_0d0e0f80);         // Sub wraps
		add_case(5'd2, 128'hf0f0f0f0_aaaaaaaa_12345678_ffffffff,
			128'h0ff0f00f_55aa55aa_ff00ff00_01234567);
		add_case(5'd3, 128'hf0f0f0f0_aaaaaaaa_12345678_00000000,
			128'h0ff0f00f_55aa55aa_ff00ff00_01234567);
		add_case(5'd4, 128'hf0f0f0f0_aaaaaaaa_12345678_ffffffff,
			128'h0ff0f00f_55aa55aa_ff00ff00_01234567);
		add_case(5'd5, {16{8'hb5}}, 128'h0f0e0d0c_0b0a0908_07060504_03020100);
		add_case(5'd6, {16{8'hb5}}, 128'h0f0e0d0c_0b0a0908_07060504_03020100);
		add_case(5'd7, 128'h807f00ff_01fe7f80_10203040_ffff0000,
			128'h7f80ff00_fe01807f_40302010_00ffff00);
		add_case(5'd31, {4{32'hdeadbeef}}, {4{32'h12345678}}); // Undefined opcode
		add_case(5'd12, {4{32'hdeadbeef}}, {4{32'h12345678}});
		repeat (20) add_case(5'($urandom % 32), {$urandom, $urandom, $urandom, $urandom},
			{$urandom, $urandom, $urandom, $urandom});

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		compare("out_valid after reset", out_valid, 1'b0);
		compare("in_ready after reset", in_ready, 1'b1);

		// Random back-pressure pass
		foreach (cases[i]) apply_case(cases[i]);
		in_valid <= 1'b0;
		drain_results();

		// Back-to-back pass with out_ready high
		ready_random = 1'b0;
		repeat (2) @(posedge clk);
		strict = 1'b1;
		foreach (cases[i]) apply_case(cases[i]);
		in_valid <= 1'b0;
		drain_results();

		$display("test passed");
		$finish;
	end

endmodule
